//--- Bender.yml
package:
  name: fetch_frontend

sources:
  - files:
      - design/fetch_pkg.sv
      - design/imem.sv
      - design/decompressor.sv
      - design/stage_fetch.sv
      - design/fetch_queue.sv
      - design/fetch_frontend.sv
  - target: test
    files:
      - bench/tb_clock.sv
      - bench/fetch_asserts.sv
      - bench/fetch_checker.sv
      - bench/fetch_tb.sv

//--- bench/fetch_asserts.sv
`timescale 1ns/1ps

module fetch_asserts #(
    parameter int CREDITS     = 4,
    parameter int QUEUE_DEPTH = 4
) (
    input logic                    clk_i,
    input logic                    reset_i,
    input logic                    send_i,
    input logic                    credit_i,
    input logic                    push_i,
    input logic                    item_valid_i,
    input int                      credit_cnt_i,
    input int                      queue_cnt_i,
    input fetch_pkg::fetch_state_t state_i
);

    int fail_count = 0;
    int outstanding_r;   // items held by the consumer, counted at the ports

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            outstanding_r <= 0;
        end else begin
            outstanding_r <= outstanding_r + int'(send_i) - int'(credit_i);
        end
    end

    assert property (@(posedge clk_i) disable iff (reset_i) send_i |-> outstanding_r < CREDITS)
        else begin
            $error("item sent without a credit");
            fail_count++;
        end
    assert property (@(posedge clk_i) disable iff (reset_i) credit_cnt_i <= CREDITS)
        else begin
            $error("credit count above the consumer buffer size");
            fail_count++;
        end
    assert property (@(posedge clk_i) disable iff (reset_i) push_i |-> queue_cnt_i < QUEUE_DEPTH)
        else begin
            $error("push into a full queue");
            fail_count++;
        end
    assert property (@(posedge clk_i) disable iff (reset_i)
                     state_i == fetch_pkg::HALTED |-> !item_valid_i)
        else begin
            $error("fetch emitted while halted");
            fail_count++;
        end

endmodule

bind fetch_queue fetch_asserts #(.CREDITS(CREDITS), .QUEUE_DEPTH(QUEUE_DEPTH)) u_queue_asserts (
    .clk_i, .reset_i, .send_i(send), .credit_i(credit_i), .push_i(push_i), .item_valid_i(1'b0),
    .credit_cnt_i(int'(credit_r)), .queue_cnt_i(int'(count_r)), .state_i(fetch_pkg::STARTUP)
);

bind stage_fetch fetch_asserts u_fetch_asserts (
    .clk_i, .reset_i, .send_i(1'b0), .credit_i(1'b0), .push_i(1'b0), .item_valid_i(valid_o),
    .credit_cnt_i(0), .queue_cnt_i(0), .state_i(state_r)
);

//--- bench/fetch_checker.sv
`timescale 1ns/1ps

module fetch_checker #(
    parameter int MEM_WORDS   = 256,
    parameter int CREDITS     = 4,
    parameter int QUEUE_DEPTH = 4
) (
    input  logic             clk_i,
    input  logic             reset_i,
    input  logic             prog_we_i,
    input  fetch_pkg::addr_t prog_addr_i,
    input  fetch_pkg::word_t prog_data_i,
    input  logic             jmp_valid_i,
    input  fetch_pkg::addr_t jmp_addr_i,
    input  logic             jmp_ready_o,
    input  logic             halt_i,
    input  logic             credit_i,
    input  logic             out_valid_o,
    input  fetch_pkg::addr_t out_pc_o,
    input  fetch_pkg::word_t out_ir_o,
    input  fetch_pkg::addr_t out_pc_next_o,
    input  logic [8*12-1:0]  test_name_i,
    output int               errors_o,
    output int               items_o
);

    fetch_pkg::word_t mem [MEM_WORDS];   // copy of the program
    fetch_pkg::addr_t jumps [$];         // taken targets not yet seen
    fetch_pkg::addr_t exp_pc;
    int received;
    int returned;
    int after_halt;
    logic halted;

    initial errors_o = 0;

    function automatic logic [15:0] half_at(input fetch_pkg::addr_t a);
        fetch_pkg::word_t w;
        w = mem[(a >> 2) % MEM_WORDS];
        return a[1] ? w[31:16] : w[15:0];
    endfunction

    function automatic fetch_pkg::word_t i_type(input int imm, input int rs1, input int rd);
        return {12'(imm), 5'(rs1), 3'b000, 5'(rd), 7'h13};
    endfunction

    // RV32C to RV32I per the ISA manual, unsupported gives zero
    function automatic fetch_pkg::word_t expand(input logic [15:0] h);
        int rd;
        int rs2;
        int imm;
        logic [20:0] off;
        rd  = h[11:7];
        rs2 = h[6:2];
        imm = $signed({h[12], h[6:2]});
        off = 21'($signed({h[12], h[8], h[10:9], h[6], h[7], h[2], h[11], h[5:3], 1'b0}));
        if (h[1:0] == 2'b01 && h[15:13] == 3'b000) return i_type(imm, rd, rd);
        if (h[1:0] == 2'b01 && h[15:13] == 3'b010) return i_type(imm, 0, rd);
        if (h[1:0] == 2'b01 && h[15:13] == 3'b011 && rd != 2 && imm != 0)
            return {20'(imm), 5'(rd), 7'h37};
        if (h[1:0] == 2'b01 && h[15:13] == 3'b101)
            return {off[20], off[10:1], off[11], off[19:12], 5'd0, 7'h6f};
        if (h[1:0] == 2'b10 && h[15:13] == 3'b100 && rs2 != 0)
            return {7'd0, 5'(rs2), h[12] ? 5'(rd) : 5'd0, 3'b000, 5'(rd), 7'h33};
        return '0;
    endfunction

    task automatic check_item();
        logic [15:0] h;
        fetch_pkg::word_t exp_ir;
        int len;
        logic found;
        if (out_pc_o != exp_pc) begin
            found = 1'b0;
            while (jumps.size() > 0 && !found) found = (jumps.pop_front() == out_pc_o);
            if (!found) begin
                $display("FAILED %0s pc: expected %h actual %h", test_name_i, exp_pc, out_pc_o);
                errors_o++;
            end
        end
        h      = half_at(out_pc_o);
        len    = (h[1:0] == 2'b11) ? 4 : 2;
        exp_ir = (len == 4) ? {half_at(out_pc_o + 2), h} : expand(h);
        if (out_ir_o !== exp_ir) begin
            $display("FAILED %0s ir at %h: expected %h actual %h",
                     test_name_i, out_pc_o, exp_ir, out_ir_o);
            errors_o++;
        end
        if (out_pc_next_o !== out_pc_o + len) begin
            $display("FAILED %0s pc_next: expected %h actual %h",
                     test_name_i, out_pc_o + len, out_pc_next_o);
            errors_o++;
        end
        exp_pc = out_pc_o + len;
    endtask

    always @(posedge clk_i) begin
        if (prog_we_i) mem[(prog_addr_i >> 2) % MEM_WORDS] = prog_data_i;
        if (reset_i) begin
            exp_pc = '0;
            jumps.delete();
            received = 0;
            returned = 0;
            after_halt = 0;
            halted = 1'b0;
            items_o = 0;
        end else begin
            if (jmp_valid_i && jmp_ready_o) jumps.push_back(jmp_addr_i);
            if (halted && jmp_ready_o) begin
                $display("jump ready went high after halt in test %0s", test_name_i);
                errors_o++;
            end
            if (credit_i) returned++;
            if (out_valid_o) begin
                received++;
                items_o++;
                if (halted) after_halt++;
                check_item();
            end
            if (received - returned > CREDITS || returned > received) begin
                $display("sink holds %0d items in test %0s", received - returned, test_name_i);
                errors_o++;
            end
            if (after_halt > QUEUE_DEPTH + 1) begin
                $display("items still leave after halt in test %0s", test_name_i);
                errors_o++;
                after_halt = 0;
            end
            if (halt_i) halted = 1'b1;
        end
    end

endmodule

//--- bench/fetch_tb.sv
`timescale 1ns/1ps

module fetch_tb;

    localparam int MEM_WORDS   = 64;
    localparam int CREDITS     = 4;
    localparam int QUEUE_DEPTH = 4;
    localparam int NUM_TESTS   = 4;
    localparam int ITEMS       = 200;   // items per test before the halt
    localparam longint TIMEOUT_NS = 10 * NUM_TESTS * (ITEMS * 20 + MEM_WORDS + 200);

    logic             clk_i;
    logic             reset_i;
    logic             reset_req;
    logic             halt_i;
    logic             jmp_valid_i;
    fetch_pkg::addr_t jmp_addr_i;
    logic             jmp_ready_o;
    logic             prog_we_i;
    fetch_pkg::addr_t prog_addr_i;
    fetch_pkg::word_t prog_data_i;
    logic             credit_i;
    logic             out_valid_o;
    fetch_pkg::addr_t out_pc_o;
    fetch_pkg::word_t out_ir_o;
    fetch_pkg::addr_t out_pc_next_o;

    int               errors;
    int               items;
    int unsigned      rng_state;
    logic [15:0]      prog_half [MEM_WORDS*2];
    int               starts [$];   // half-word index of every instruction start
    int               mode;
    int               sink_held;
    int               cycle;
    int               failed_tests;
    logic [8*12-1:0]  test_name;

    tb_clock u_clock (.reset_req_i(reset_req), .clk_o(clk_i), .reset_o(reset_i));

    fetch_frontend #(
        .MEM_WORDS   (MEM_WORDS),
        .CREDITS     (CREDITS),
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) DUT (
        .clk_i, .reset_i, .halt_i, .jmp_valid_i, .jmp_addr_i, .jmp_ready_o,
        .prog_we_i, .prog_addr_i, .prog_data_i, .credit_i,
        .out_valid_o, .out_pc_o, .out_ir_o, .out_pc_next_o
    );

    fetch_checker #(
        .MEM_WORDS   (MEM_WORDS),
        .CREDITS     (CREDITS),
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_checker (
        .clk_i, .reset_i, .prog_we_i, .prog_addr_i, .prog_data_i,
        .jmp_valid_i, .jmp_addr_i, .jmp_ready_o, .halt_i, .credit_i,
        .out_valid_o, .out_pc_o, .out_ir_o, .out_pc_next_o,
        .test_name_i (test_name),
        .errors_o    (errors),
        .items_o     (items)
    );

    function automatic int unsigned next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return {8'h00, rng_state[31:8]};   // low LCG bits are weak
    endfunction

    // failures reported by the bound assertion instances
    function automatic int assertion_failures();
        return DUT.u_fetch_queue.u_queue_asserts.fail_count
               + DUT.u_stage_fetch.u_fetch_asserts.fail_count;
    endfunction

    function automatic logic [15:0] random_compressed();
        logic [4:0] rd;
        logic [4:0] rs2;
        logic [5:0] imm;
        logic [15:0] h;
        rd  = 5'(next_rand() % 31 + 1);
        rs2 = 5'(next_rand() % 31 + 1);
        imm = 6'(next_rand());
        case (next_rand() % 7)
            0: h = {3'b000, imm[5], rd, imm[4:0], 2'b01};   // c.addi
            1: h = 16'h0001;                                // c.nop
            2: h = {3'b010, imm[5], rd, imm[4:0], 2'b01};   // c.li
            3: begin
                if (rd == 5'd2) rd = 5'd3;
                if (imm == 6'd0) imm = 6'd1;
                h = {3'b011, imm[5], rd, imm[4:0], 2'b01};  // c.lui
            end
            4: h = {4'b1000, rd, rs2, 2'b10};               // c.mv
            5: h = {4'b1001, rd, rs2, 2'b10};               // c.add
            default: h = {3'b101, 11'(next_rand()), 2'b01}; // c.j
        endcase
        return h;
    endfunction

    // random mix of 16 and 32 bit slots loaded while reset is held
    task automatic load_program();
        int idx;
        logic [31:0] w;
        idx = 0;
        starts.delete();
        while (idx < MEM_WORDS * 2) begin
            starts.push_back(idx);
            if (idx == MEM_WORDS * 2 - 1 || next_rand() % 2 == 0) begin
                prog_half[idx] = random_compressed();
                idx++;
            end else begin
                w = {16'(next_rand()), 14'(next_rand()), 2'b11};
                prog_half[idx]     = w[15:0];
                prog_half[idx + 1] = w[31:16];
                idx += 2;
            end
        end
        reset_req <= 1'b1;
        for (int i = 0; i < MEM_WORDS; i++) begin
            @(posedge clk_i);
            prog_we_i   <= 1'b1;
            prog_addr_i <= 32'(i * 4);
            prog_data_i <= {prog_half[2*i+1], prog_half[2*i]};
        end
        @(posedge clk_i);
        prog_we_i <= 1'b0;
        reset_req <= 1'b0;
    endtask

    // called right after an edge, so it sees the values from before it
    task automatic step_cycle();
        logic drain_ok;
        int   held;
        cycle++;
        if (jmp_valid_i && jmp_ready_o) begin
            jmp_valid_i <= 1'b0;
        end else if (!jmp_valid_i && !halt_i && mode != 0 && next_rand() % 12 == 0) begin
            jmp_valid_i <= 1'b1;
            jmp_addr_i  <= 32'(starts[next_rand() % starts.size()] * 2);
        end
        held = sink_held + int'(out_valid_o);
        if (halt_i || mode == 0) drain_ok = 1'b1;
        else if (mode == 2) drain_ok = (cycle % 64) >= 40;   // long starvation
        else drain_ok = (next_rand() % 100) < 50;
        if (held > 0 && drain_ok) begin
            held--;
            credit_i <= 1'b1;
        end else begin
            credit_i <= 1'b0;
        end
        sink_held = held;
    endtask

    initial begin
        int errors_before;
        int asserts_before;
        int idle;
        halt_i       = 1'b0;
        jmp_valid_i  = 1'b0;
        jmp_addr_i   = '0;
        prog_we_i    = 1'b0;
        prog_addr_i  = '0;
        prog_data_i  = '0;
        credit_i     = 1'b0;
        reset_req    = 1'b1;
        rng_state    = 27406;
        failed_tests = 0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            mode = t;
            case (t)
                0: test_name = "sequential";
                1: test_name = "jumps";
                2: test_name = "starvation";
                default: test_name = "mixed";
            endcase
            errors_before  = errors;
            asserts_before = assertion_failures();
            load_program();
            while (reset_i) @(posedge clk_i);
            cycle     = 0;
            sink_held = 0;
            while (items < ITEMS) begin
                @(posedge clk_i);
                step_cycle();
            end
            halt_i <= 1'b1;
            idle = 0;
            while (idle < 20) begin   // queue drained once outputs go quiet
                @(posedge clk_i);
                step_cycle();
                idle = out_valid_o ? 0 : idle + 1;
            end
            if (errors == errors_before && assertion_failures() == asserts_before) begin
                $display("test %0s: passed, %0d items", test_name, items);
            end else begin
                $display("test %0s: failed, %0d errors, %0d assertion failures", test_name,
                         errors - errors_before, assertion_failures() - asserts_before);
                failed_tests++;
            end
            reset_req   <= 1'b1;
            halt_i      <= 1'b0;
            jmp_valid_i <= 1'b0;
            credit_i    <= 1'b0;
        end
        $display("%0d tests, %0d failed, %0d errors, %0d assertion failures",
                 NUM_TESTS, failed_tests, errors, assertion_failures());
        if (failed_tests == 0 && errors == 0 && assertion_failures() == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired before all tests finished");
        $display("Regression failed");
        $finish;
    end

endmodule

//--- bench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    input  logic reset_req_i,   // restarts the 16-cycle reset while high
    output logic clk_o,
    output logic reset_o
);

    int cycles_r;

    initial begin
        clk_o    = 1'b0;
        cycles_r = 0;
    end

    always #5 clk_o = ~clk_o;   // 10 ns period

    always @(posedge clk_o) begin
        if (reset_req_i) begin
            cycles_r <= 0;
        end else if (cycles_r < 16) begin
            cycles_r <= cycles_r + 1;
        end
    end

    assign reset_o = (cycles_r < 16);

endmodule

//--- design/decompressor.sv
`timescale 1ns/1ps

module decompressor (
    input  fetch_pkg::word_t ir_i,
    output fetch_pkg::word_t ir_o,
    output logic             compressed_o
);

    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    logic [4:0]       rd;
    logic [4:0]       rs2;
    logic [5:0]       imm6;
    logic [11:0]      imm12;
    logic [19:0]      lui_imm;
    logic [19:0]      jal_imm;
    fetch_pkg::word_t expanded;

    assign compressed_o = (ir_i[1:0] != 2'b11);

    // common CI / CR fields
    assign rd   = ir_i[11:7];
    assign rs2  = ir_i[6:2];
    assign imm6 = {ir_i[12], ir_i[6:2]};

    assign imm12   = {{6{imm6[5]}}, imm6};
    assign lui_imm = {{14{imm6[5]}}, imm6};   // nzimm[17:12] into upper bits

    // c.j offset scattered over the CJ format, repacked as the jal immediate
    assign jal_imm = {
        ir_i[12],                                   // imm[20]
        ir_i[8], ir_i[10:9], ir_i[6], ir_i[7],      // imm[10:6]
        ir_i[2], ir_i[11], ir_i[5:3],               // imm[5:1]
        ir_i[12],                                   // imm[11]
        {8{ir_i[12]}}                               // imm[19:12]
    };

    always_comb begin
        expanded = '0;   // unsupported patterns stay illegal
        case (ir_i[1:0])
            2'b01: begin
                case (ir_i[15:13])
                    3'b000: begin
                        // c.addi, c.nop when rd and imm are zero
                        expanded = {imm12, rd, 3'b000, rd, OPC_OP_IMM};
                    end
                    3'b010: begin
                        expanded = {imm12, 5'd0, 3'b000, rd, OPC_OP_IMM};   // c.li
                    end
                    3'b011: begin
                        // rd == 2 is c.addi16sp, not handled
                        if (rd != 5'd2 && imm6 != 6'd0) begin
                            expanded = {lui_imm, rd, OPC_LUI};
                        end
                    end
                    3'b101: begin
                        expanded = {jal_imm, 5'd0, OPC_JAL};   // c.j, link to x0
                    end
                    default: begin
                        expanded = '0;
                    end
                endcase
            end
            2'b10: begin
                // rs2 == 0 would be c.jr / c.jalr / c.ebreak
                if (ir_i[15:13] == 3'b100 && rs2 != 5'd0) begin
                    if (ir_i[12]) begin
                        expanded = {7'd0, rs2, rd, 3'b000, rd, OPC_OP};     // c.add
                    end else begin
                        expanded = {7'd0, rs2, 5'd0, 3'b000, rd, OPC_OP};   // c.mv
                    end
                end
            end
            default: begin
                expanded = '0;
            end
        endcase
    end

    // full-size instructions pass untouched
    assign ir_o = compressed_o ? expanded : ir_i;

endmodule

//--- design/fetch_frontend.sv
`timescale 1ns/1ps

module fetch_frontend #(
    parameter int MEM_WORDS   = 256,
    parameter int CREDITS     = 4,
    parameter int QUEUE_DEPTH = 4
) (
    input  logic             clk_i,
    input  logic             reset_i,
    input  logic             halt_i,

    input  logic             jmp_valid_i,
    input  fetch_pkg::addr_t jmp_addr_i,
    output logic             jmp_ready_o,

    input  logic             prog_we_i,
    input  fetch_pkg::addr_t prog_addr_i,
    input  fetch_pkg::word_t prog_data_i,

    input  logic             credit_i,
    output logic             out_valid_o,
    output fetch_pkg::addr_t out_pc_o,
    output fetch_pkg::word_t out_ir_o,
    output fetch_pkg::addr_t out_pc_next_o
);

    fetch_pkg::addr_t imem_addr;
    fetch_pkg::word_t imem_data;

    logic             fetch_valid;
    logic             fetch_ready;
    fetch_pkg::addr_t fetch_pc;
    fetch_pkg::word_t fetch_ir;
    fetch_pkg::addr_t fetch_pc_next;

    imem #(
        .MEM_WORDS (MEM_WORDS)
    ) u_imem (
        .clk_i   (clk_i),
        .we_i    (prog_we_i),
        .waddr_i (prog_addr_i),
        .wdata_i (prog_data_i),
        .raddr_i (imem_addr),
        .rdata_o (imem_data)
    );

    stage_fetch u_stage_fetch (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .halt_i      (halt_i),
        .imem_addr_o (imem_addr),
        .imem_data_i (imem_data),
        .jmp_valid_i (jmp_valid_i),
        .jmp_addr_i  (jmp_addr_i),
        .jmp_ready_o (jmp_ready_o),
        .ready_i     (fetch_ready),
        .valid_o     (fetch_valid),
        .pc_o        (fetch_pc),
        .ir_o        (fetch_ir),
        .pc_next_o   (fetch_pc_next)
    );

    fetch_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH),
        .CREDITS     (CREDITS)
    ) u_fetch_queue (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .push_i        (fetch_valid),
        .pc_i          (fetch_pc),
        .ir_i          (fetch_ir),
        .pc_next_i     (fetch_pc_next),
        .ready_o       (fetch_ready),
        .credit_i      (credit_i),
        .out_valid_o   (out_valid_o),
        .out_pc_o      (out_pc_o),
        .out_ir_o      (out_ir_o),
        .out_pc_next_o (out_pc_next_o)
    );

endmodule

//--- design/fetch_pkg.sv
package fetch_pkg;

    // widths that carry a meaning across the front end
    typedef logic [31:0] word_t;   // instruction or data word
    typedef logic [31:0] addr_t;   // byte address, pc and jump target
    typedef logic [15:0] half_t;   // upper half of a word kept across a boundary

    // fetch FSM, one-hot
    typedef enum logic [4:0] {
        STARTUP        = 5'b00001,   // memory pipeline filling
        ALIGNED        = 5'b00010,   // next instruction starts at bit 0 of the word
        UNALIGNED      = 5'b00100,   // next instruction starts in the saved half
        UNALIGNED_JUMP = 5'b01000,   // first word of an unaligned target in flight
        HALTED         = 5'b10000    // terminal
    } fetch_state_t;

    // placeholders driven while no instruction is valid
    localparam word_t NOP_IR = 32'h0000_0013;   // addi x0, x0, 0
    localparam addr_t NOP_PC = 32'hffff_ffff;

endpackage

//--- design/fetch_queue.sv
`timescale 1ns/1ps

module fetch_queue #(
    parameter int QUEUE_DEPTH = 4,
    parameter int CREDITS     = 4
) (
    input  logic             clk_i,
    input  logic             reset_i,

    // from fetch
    input  logic             push_i,
    input  fetch_pkg::addr_t pc_i,
    input  fetch_pkg::word_t ir_i,
    input  fetch_pkg::addr_t pc_next_i,
    output logic             ready_o,

    // to the consumer
    input  logic             credit_i,
    output logic             out_valid_o,
    output fetch_pkg::addr_t out_pc_o,
    output fetch_pkg::word_t out_ir_o,
    output fetch_pkg::addr_t out_pc_next_o
);

    localparam int PW = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CW = $clog2(QUEUE_DEPTH + 1);
    localparam int KW = $clog2(CREDITS + 1);
    localparam logic [PW-1:0] LAST_PTR   = PW'(QUEUE_DEPTH - 1);
    localparam logic [CW-1:0] FULL_CNT   = CW'(QUEUE_DEPTH);
    localparam logic [CW-1:0] ALMOST_CNT = CW'(QUEUE_DEPTH - 1);

    fetch_pkg::addr_t pc_mem      [QUEUE_DEPTH];
    fetch_pkg::word_t ir_mem      [QUEUE_DEPTH];
    fetch_pkg::addr_t pc_next_mem [QUEUE_DEPTH];

    logic [PW-1:0] wr_ptr_r;
    logic [PW-1:0] rd_ptr_r;
    logic [CW-1:0] count_r;
    logic [KW-1:0] credit_r;   // free slots on the consumer side
    logic          send;

    function automatic logic [PW-1:0] ptr_inc(input logic [PW-1:0] ptr);
        return (ptr == LAST_PTR) ? '0 : ptr + 1'b1;
    endfunction

    assign send = (count_r != '0) && (credit_r != '0);

    // leaves room for the item fetch already has on its outputs
    assign ready_o = push_i ? (count_r < ALMOST_CNT) : (count_r < FULL_CNT);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wr_ptr_r <= '0;
            rd_ptr_r <= '0;
            count_r  <= '0;
            credit_r <= KW'(CREDITS);
        end else begin
            if (push_i) begin
                wr_ptr_r <= ptr_inc(wr_ptr_r);
            end
            if (send) begin
                rd_ptr_r <= ptr_inc(rd_ptr_r);
            end
            case ({push_i, send})
                2'b10:   count_r <= count_r + 1'b1;
                2'b01:   count_r <= count_r - 1'b1;
                default: count_r <= count_r;
            endcase
            case ({credit_i, send})
                2'b10:   credit_r <= credit_r + 1'b1;   // consumer freed a slot
                2'b01:   credit_r <= credit_r - 1'b1;
                default: credit_r <= credit_r;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            pc_mem[wr_ptr_r]      <= pc_i;
            ir_mem[wr_ptr_r]      <= ir_i;
            pc_next_mem[wr_ptr_r] <= pc_next_i;
        end
    end

    assign out_valid_o   = send;
    assign out_pc_o      = pc_mem[rd_ptr_r];
    assign out_ir_o      = ir_mem[rd_ptr_r];
    assign out_pc_next_o = pc_next_mem[rd_ptr_r];

endmodule

//--- design/imem.sv
`timescale 1ns/1ps

module imem #(
    parameter int MEM_WORDS = 256
) (
    input  logic             clk_i,

    // program write port, used while reset is held
    input  logic             we_i,
    input  fetch_pkg::addr_t waddr_i,
    input  fetch_pkg::word_t wdata_i,

    // fetch read port
    input  fetch_pkg::addr_t raddr_i,
    output fetch_pkg::word_t rdata_o
);

    localparam int AW = $clog2(MEM_WORDS);

    fetch_pkg::word_t mem [MEM_WORDS];

    logic [AW-1:0] widx;
    logic [AW-1:0] ridx;

    // word index, wraps modulo the depth
    assign widx = waddr_i[AW+1:2];
    assign ridx = raddr_i[AW+1:2];

    always_ff @(posedge clk_i) begin
        if (we_i) begin
            mem[widx] <= wdata_i;
        end
    end

    // data shows up one cycle after the address
    always_ff @(posedge clk_i) begin
        rdata_o <= mem[ridx];
    end

endmodule

//--- design/stage_fetch.sv
`timescale 1ns/1ps

module stage_fetch (
    input  logic             clk_i,
    input  logic             reset_i,
    input  logic             halt_i,

    // instruction memory
    output fetch_pkg::addr_t imem_addr_o,
    input  fetch_pkg::word_t imem_data_i,

    // jump request, held by the requester until taken
    input  logic             jmp_valid_i,
    input  fetch_pkg::addr_t jmp_addr_i,
    output logic             jmp_ready_o,

    // toward the queue
    input  logic             ready_i,
    output logic             valid_o,
    output fetch_pkg::addr_t pc_o,
    output fetch_pkg::word_t ir_o,
    output fetch_pkg::addr_t pc_next_o
);

    logic [1:0] first_cycle_r;

    fetch_pkg::fetch_state_t state_r;
    fetch_pkg::fetch_state_t state_next;

    // transitions
    logic halt;
    logic waiting;
    logic run_aligned;
    logic run_unaligned;
    logic jump;
    logic aligned_jump;
    logic unaligned_jump_1;
    logic unaligned_jump_2;
    logic advance;
    logic stay_aligned;
    logic lose_alignment;
    logic stay_unaligned;
    logic gain_alignment;
    logic emit;

    fetch_pkg::word_t candidate_ir;
    fetch_pkg::word_t decompressed_ir;
    logic             compressed;

    fetch_pkg::addr_t imem_addr;
    fetch_pkg::addr_t imem_addr_r;   // address of the word now on imem_data_i
    fetch_pkg::addr_t pc_next_r;
    fetch_pkg::addr_t jmp_addr_r;
    fetch_pkg::half_t saved_ir_r;

    // two cycles for the memory read pipe to fill
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            first_cycle_r <= 2'b11;
        end else begin
            first_cycle_r <= {1'b0, first_cycle_r[1]};
        end
    end

    assign jmp_ready_o = (state_r == fetch_pkg::ALIGNED || state_r == fetch_pkg::UNALIGNED)
                         && !halt_i && ready_i;

    always_comb begin
        halt             = (state_r == fetch_pkg::HALTED) || halt_i;
        waiting          = (state_r == fetch_pkg::STARTUP) && first_cycle_r[0];
        run_aligned      = ((state_r == fetch_pkg::STARTUP) && !first_cycle_r[0])
                           || (state_r == fetch_pkg::ALIGNED);
        run_unaligned    = (state_r == fetch_pkg::UNALIGNED);
        jump             = jmp_valid_i && jmp_ready_o;
        aligned_jump     = jump && (jmp_addr_i[1:0] == 2'b00);
        unaligned_jump_1 = jump && (jmp_addr_i[1:0] != 2'b00);
        unaligned_jump_2 = (state_r == fetch_pkg::UNALIGNED_JUMP) && !halt_i;
        advance          = !halt_i && ready_i && !jump;   // a jump drops this slot
        stay_aligned     = run_aligned   && advance && !compressed;
        lose_alignment   = run_aligned   && advance &&  compressed;
        stay_unaligned   = run_unaligned && advance && !compressed;
        gain_alignment   = run_unaligned && advance &&  compressed;
        emit             = stay_aligned || lose_alignment || stay_unaligned || gain_alignment;
    end

    always_comb begin
        if (halt) begin
            state_next = fetch_pkg::HALTED;   // never left
        end else if (waiting) begin
            state_next = fetch_pkg::STARTUP;
        end else if (stay_aligned || gain_alignment || aligned_jump) begin
            state_next = fetch_pkg::ALIGNED;
        end else if (lose_alignment || stay_unaligned || unaligned_jump_2) begin
            state_next = fetch_pkg::UNALIGNED;
        end else if (unaligned_jump_1) begin
            state_next = fetch_pkg::UNALIGNED_JUMP;
        end else begin
            state_next = state_r;   // stall
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_r <= fetch_pkg::STARTUP;
        end else begin
            state_r <= state_next;
        end
    end

    // instruction candidate for this cycle
    always_comb begin
        if (run_aligned) begin
            candidate_ir = imem_data_i;
        end else if (run_unaligned) begin
            candidate_ir = {imem_data_i[15:0], saved_ir_r};
        end else begin
            candidate_ir = fetch_pkg::NOP_IR;
        end
    end

    decompressor u_decompressor (
        .ir_i         (candidate_ir),
        .ir_o         (decompressed_ir),
        .compressed_o (compressed)
    );

    always_comb begin
        if (waiting) begin
            imem_addr = '0;
        end else if (stay_aligned || lose_alignment || stay_unaligned || unaligned_jump_2) begin
            imem_addr = imem_addr_r + 32'd4;
        end else if (aligned_jump || unaligned_jump_1) begin
            imem_addr = {jmp_addr_i[31:2], 2'b00};
        end else begin
            imem_addr = imem_addr_r;   // stall, halt, or reread on gain_alignment
        end
    end

    assign imem_addr_o = imem_addr;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            imem_addr_r <= '0;
        end else begin
            imem_addr_r <= imem_addr;
        end
    end

    // registered item, one shot per emitted instruction
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_o <= 1'b0;
            pc_o    <= fetch_pkg::NOP_PC;
            ir_o    <= fetch_pkg::NOP_IR;
        end else begin
            valid_o <= emit;
            pc_o    <= emit ? pc_next_r : fetch_pkg::NOP_PC;
            ir_o    <= emit ? decompressed_ir : fetch_pkg::NOP_IR;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            pc_next_r <= '0;
        end else if (halt) begin
            pc_next_r <= fetch_pkg::NOP_PC;
        end else if (waiting) begin
            pc_next_r <= '0;
        end else if (lose_alignment || gain_alignment) begin
            pc_next_r <= pc_next_r + 32'd2;
        end else if (stay_aligned || stay_unaligned) begin
            pc_next_r <= pc_next_r + 32'd4;
        end else if (aligned_jump) begin
            pc_next_r <= jmp_addr_i;
        end else if (unaligned_jump_2) begin
            pc_next_r <= jmp_addr_r;
        end
    end

    assign pc_next_o = pc_next_r;

    always_ff @(posedge clk_i) begin
        if (unaligned_jump_1) begin
            jmp_addr_r <= jmp_addr_i;
        end
    end

    // upper half that starts the next instruction
    always_ff @(posedge clk_i) begin
        if (lose_alignment || stay_unaligned || unaligned_jump_2) begin
            saved_ir_r <= imem_data_i[31:16];
        end
    end

endmodule

//--- tb.f
design/fetch_pkg.sv
design/imem.sv
design/decompressor.sv
design/stage_fetch.sv
design/fetch_queue.sv
design/fetch_frontend.sv
bench/tb_clock.sv
bench/fetch_asserts.sv
bench/fetch_checker.sv
bench/fetch_tb.sv
